// File: hw/branch_pkg.sv
package branch_pkg;

    // widths that carry a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  br_class_t;

    // instruction classes seen by the resolve pipeline
    localparam br_class_t CLS_NONE = 4'd0;
    localparam br_class_t CLS_BEQ  = 4'd1;
    localparam br_class_t CLS_BNE  = 4'd2;
    localparam br_class_t CLS_BLEZ = 4'd3;
    localparam br_class_t CLS_BGTZ = 4'd4;
    localparam br_class_t CLS_BLTZ = 4'd5;
    localparam br_class_t CLS_BGEZ = 4'd6;
    localparam br_class_t CLS_J    = 4'd7;
    localparam br_class_t CLS_JAL  = 4'd8;
    localparam br_class_t CLS_JR   = 4'd9;
    localparam br_class_t CLS_JALR = 4'd10;

    // primary opcode field, bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;

    // function field of SPECIAL, bits 5:0
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;

    // rt field of REGIMM, bits 20:16
    localparam logic [4:0] RT_BLTZ = 5'b00000;
    localparam logic [4:0] RT_BGEZ = 5'b00001;

    // link register, a jr through it is a return
    localparam reg_idx_t RA_IDX = 5'd31;

    // distance from a branch to its delay slot
    localparam addr_t SLOT_STEP = 32'd4;

endpackage

// File: hw/branch_ifs.sv
`timescale 1ns/1ps

// decode -> execute
interface decoded_if;

    logic                  valid;
    logic                  ready;
    branch_pkg::addr_t     pc;
    branch_pkg::br_class_t cls;
    // sign extended, already in bytes
    branch_pkg::addr_t     offset;
    logic [25:0]           jump_index;
    branch_pkg::reg_idx_t  rs_idx;
    branch_pkg::word_t     src_a;
    branch_pkg::word_t     src_b;
    logic                  pred_taken;

    modport src (
        output valid, pc, cls, offset, jump_index, rs_idx, src_a, src_b, pred_taken,
        input  ready
    );

    modport dst (
        input  valid, pc, cls, offset, jump_index, rs_idx, src_a, src_b, pred_taken,
        output ready
    );

endinterface

// execute -> result
interface resolved_if;

    logic                  valid;
    logic                  ready;
    branch_pkg::addr_t     pc;
    branch_pkg::br_class_t cls;
    // actual outcome, always set for jumps
    logic                  cond_true;
    branch_pkg::addr_t     dest;
    branch_pkg::reg_idx_t  rs_idx;
    logic                  pred_taken;

    modport src (
        output valid, pc, cls, cond_true, dest, rs_idx, pred_taken,
        input  ready
    );

    modport dst (
        input  valid, pc, cls, cond_true, dest, rs_idx, pred_taken,
        output ready
    );

endinterface

// File: hw/branch_decode.sv
`timescale 1ns/1ps

module branch_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  branch_pkg::addr_t  in_pc,
    input  branch_pkg::instr_t in_instr,
    input  logic               in_pred_taken,
    input  branch_pkg::word_t  in_src_a,
    input  branch_pkg::word_t  in_src_b,
    decoded_if.src             dec
);

    logic               valid_q;
    branch_pkg::addr_t  pc_q;
    branch_pkg::instr_t instr_q;
    logic               pred_q;
    branch_pkg::word_t  src_a_q;
    branch_pkg::word_t  src_b_q;

    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [4:0]            rt;
    branch_pkg::br_class_t cls;

    // one slot, refills in the same cycle it drains
    assign in_ready = ~valid_q | dec.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            pc_q    <= in_pc;
            instr_q <= in_instr;
            pred_q  <= in_pred_taken;
            src_a_q <= in_src_a;
            src_b_q <= in_src_b;
        end
    end

    assign opcode = instr_q[31:26];
    assign rt     = instr_q[20:16];
    assign funct  = instr_q[5:0];

    always_comb begin
        cls = branch_pkg::CLS_NONE;
        case (opcode)
            branch_pkg::OP_SPECIAL: begin
                if (funct == branch_pkg::FN_JR) begin
                    cls = branch_pkg::CLS_JR;
                end else if (funct == branch_pkg::FN_JALR) begin
                    cls = branch_pkg::CLS_JALR;
                end
            end
            branch_pkg::OP_REGIMM: begin
                // only the two plain compares, no link variants
                if (rt == branch_pkg::RT_BLTZ) begin
                    cls = branch_pkg::CLS_BLTZ;
                end else if (rt == branch_pkg::RT_BGEZ) begin
                    cls = branch_pkg::CLS_BGEZ;
                end
            end
            branch_pkg::OP_J:    cls = branch_pkg::CLS_J;
            branch_pkg::OP_JAL:  cls = branch_pkg::CLS_JAL;
            branch_pkg::OP_BEQ:  cls = branch_pkg::CLS_BEQ;
            branch_pkg::OP_BNE:  cls = branch_pkg::CLS_BNE;
            branch_pkg::OP_BLEZ: cls = branch_pkg::CLS_BLEZ;
            branch_pkg::OP_BGTZ: cls = branch_pkg::CLS_BGTZ;
            default:             cls = branch_pkg::CLS_NONE;
        endcase
    end

    assign dec.valid      = valid_q;
    assign dec.pc         = pc_q;
    assign dec.cls        = cls;
    // 16 bit word offset to byte offset
    assign dec.offset     = {{14{instr_q[15]}}, instr_q[15:0], 2'b00};
    assign dec.jump_index = instr_q[25:0];
    assign dec.rs_idx     = instr_q[25:21];
    assign dec.src_a      = src_a_q;
    assign dec.src_b      = src_b_q;
    assign dec.pred_taken = pred_q;

endmodule

// File: hw/branch_execute.sv
`timescale 1ns/1ps

module branch_execute (
    input  logic    clk,
    input  logic    reset,
    decoded_if.dst  dec,
    resolved_if.src res
);

    logic                  valid_q;
    branch_pkg::addr_t     pc_q;
    branch_pkg::br_class_t cls_q;
    logic                  cond_q;
    branch_pkg::addr_t     dest_q;
    branch_pkg::reg_idx_t  rs_q;
    logic                  pred_q;

    logic              a_neg;
    logic              a_zero;
    logic              cond;
    branch_pkg::addr_t slot_pc;
    branch_pkg::addr_t dest;

    assign dec.ready = ~valid_q | res.ready;

    // compares against zero only look at rs
    assign a_neg  = dec.src_a[31];
    assign a_zero = (dec.src_a == '0);

    always_comb begin
        case (dec.cls)
            branch_pkg::CLS_BEQ:  cond = (dec.src_a == dec.src_b);
            branch_pkg::CLS_BNE:  cond = (dec.src_a != dec.src_b);
            branch_pkg::CLS_BLEZ: cond = a_neg | a_zero;
            branch_pkg::CLS_BGTZ: cond = ~a_neg & ~a_zero;
            branch_pkg::CLS_BLTZ: cond = a_neg;
            branch_pkg::CLS_BGEZ: cond = ~a_neg;
            branch_pkg::CLS_J,
            branch_pkg::CLS_JAL,
            branch_pkg::CLS_JR,
            branch_pkg::CLS_JALR: cond = 1'b1;
            default:              cond = 1'b0;
        endcase
    end

    assign slot_pc = dec.pc + branch_pkg::SLOT_STEP;

    always_comb begin
        case (dec.cls)
            branch_pkg::CLS_BEQ,
            branch_pkg::CLS_BNE,
            branch_pkg::CLS_BLEZ,
            branch_pkg::CLS_BGTZ,
            branch_pkg::CLS_BLTZ,
            branch_pkg::CLS_BGEZ: dest = slot_pc + dec.offset;
            // region of the delay slot, not of the jump itself
            branch_pkg::CLS_J,
            branch_pkg::CLS_JAL:  dest = {slot_pc[31:28], dec.jump_index, 2'b00};
            branch_pkg::CLS_JR,
            branch_pkg::CLS_JALR: dest = dec.src_a;
            default:              dest = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (dec.ready) begin
            valid_q <= dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.valid && dec.ready) begin
            pc_q   <= dec.pc;
            cls_q  <= dec.cls;
            cond_q <= cond;
            dest_q <= dest;
            rs_q   <= dec.rs_idx;
            pred_q <= dec.pred_taken;
        end
    end

    assign res.valid      = valid_q;
    assign res.pc         = pc_q;
    assign res.cls        = cls_q;
    assign res.cond_true  = cond_q;
    assign res.dest       = dest_q;
    assign res.rs_idx     = rs_q;
    assign res.pred_taken = pred_q;

endmodule

// File: hw/branch_result.sv
`timescale 1ns/1ps

module branch_result (
    input  logic              clk,
    input  logic              reset,
    resolved_if.dst           res,
    input  logic              res_ready,
    output logic              res_valid,
    output branch_pkg::addr_t res_pc,
    output logic              res_redirect,
    output branch_pkg::addr_t res_target,
    output branch_pkg::addr_t res_dest,
    output logic              res_call,
    output logic              res_return
);

    logic              is_ctrl;
    logic              redirect;
    branch_pkg::addr_t target;
    logic              call;
    logic              ret;

    assign is_ctrl = (res.cls != branch_pkg::CLS_NONE);

    // fetch went the wrong way whenever outcome and prediction differ
    assign redirect = is_ctrl & (res.cond_true ^ res.pred_taken);

    always_comb begin
        if (redirect && res.cond_true) begin
            target = res.dest;
        end else if (redirect) begin
            // predicted taken but fell through so resume after the delay slot
            target = res.pc + branch_pkg::SLOT_STEP + branch_pkg::SLOT_STEP;
        end else begin
            target = '0;
        end
    end

    // hints for the return stack
    assign call = (res.cls == branch_pkg::CLS_JAL) || (res.cls == branch_pkg::CLS_JALR);
    assign ret  = (res.cls == branch_pkg::CLS_JR) && (res.rs_idx == branch_pkg::RA_IDX);

    assign res.ready = ~res_valid | res_ready;

    // redirect drops together with valid
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid    <= 1'b0;
            res_redirect <= 1'b0;
        end else if (res.ready) begin
            res_valid    <= res.valid;
            res_redirect <= res.valid & redirect;
        end
    end

    // fields hold while the consumer stalls
    always_ff @(posedge clk) begin
        if (res.valid && res.ready) begin
            res_pc     <= res.pc;
            res_target <= target;
            res_dest   <= res.dest;
            res_call   <= call;
            res_return <= ret;
        end
    end

endmodule

// File: hw/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    output logic               in_ready,
    input  branch_pkg::addr_t  in_pc,
    input  branch_pkg::instr_t in_instr,
    input  logic               in_pred_taken,
    input  branch_pkg::word_t  in_src_a,
    input  branch_pkg::word_t  in_src_b,

    output logic               res_valid,
    input  logic               res_ready,
    output branch_pkg::addr_t  res_pc,
    output logic               res_redirect,
    output branch_pkg::addr_t  res_target,
    output branch_pkg::addr_t  res_dest,
    output logic               res_call,
    output logic               res_return
);

    decoded_if  dec_link ();
    resolved_if res_link ();

    // classify and pick fields
    branch_decode u_decode (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_instr      (in_instr),
        .in_pred_taken (in_pred_taken),
        .in_src_a      (in_src_a),
        .in_src_b      (in_src_b),
        .dec           (dec_link)
    );

    // condition and destination
    branch_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dec   (dec_link),
        .res   (res_link)
    );

    // redirect against prediction
    branch_result u_result (
        .clk          (clk),
        .reset        (reset),
        .res          (res_link),
        .res_ready    (res_ready),
        .res_valid    (res_valid),
        .res_pc       (res_pc),
        .res_redirect (res_redirect),
        .res_target   (res_target),
        .res_dest     (res_dest),
        .res_call     (res_call),
        .res_return   (res_return)
    );

endmodule

// File: sim/branch_unit_asserts.sv
`timescale 1ns/1ps

module branch_unit_asserts (
    input logic              clk,
    input logic              reset,
    input logic              res_valid,
    input logic              res_ready,
    input branch_pkg::addr_t res_pc,
    input logic              res_redirect,
    input branch_pkg::addr_t res_target,
    input branch_pkg::addr_t res_dest,
    input logic              res_call,
    input logic              res_return
);

    // result stage comes out of reset empty
    reset_clears_valid: assert property (@(posedge clk) reset |=> !res_valid)
        else $error("res_valid high in the cycle after reset");

    // a stalled result keeps every field
    stall_holds_result: assert property (@(posedge clk) disable iff (reset)
        res_valid && !res_ready |=> res_valid && $stable(res_pc) && $stable(res_redirect)
            && $stable(res_target) && $stable(res_dest) && $stable(res_call)
            && $stable(res_return))
        else $error("result changed while res_ready was low");

    // no redirect without a result behind it
    redirect_needs_valid: assert property (@(posedge clk) disable iff (reset)
        res_redirect |-> res_valid)
        else $error("res_redirect high while res_valid was low");

endmodule

bind branch_unit branch_unit_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .res_pc       (res_pc),
    .res_redirect (res_redirect),
    .res_target   (res_target),
    .res_dest     (res_dest),
    .res_call     (res_call),
    .res_return   (res_return)
);

// File: sim/branch_unit_tb.sv
`timescale 1ns/1ps

module branch_unit_tb;

    localparam int RANDOM_ITEMS = 360;
    localparam int TIMED_ITEMS  = 40;
    localparam int TOTAL_ITEMS  = RANDOM_ITEMS + TIMED_ITEMS;
    localparam int CYCLE_LIMIT  = TOTAL_ITEMS * 4 * 4 + 50;

    typedef struct packed {
        branch_pkg::addr_t pc;
        logic              redirect;
        branch_pkg::addr_t target;
        branch_pkg::addr_t dest;
        logic              call;
        logic              ret;
        logic              timed;
        int                accept_cycle;
    } expect_t;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic               in_ready;
    branch_pkg::addr_t  in_pc;
    branch_pkg::instr_t in_instr;
    logic               in_pred_taken;
    branch_pkg::word_t  in_src_a;
    branch_pkg::word_t  in_src_b;
    logic               res_valid;
    logic               res_ready;
    branch_pkg::addr_t  res_pc;
    logic               res_redirect;
    branch_pkg::addr_t  res_target;
    branch_pkg::addr_t  res_dest;
    logic               res_call;
    logic               res_return;

    expect_t     exp_q[$];
    logic [31:0] lfsr_state = 32'he0f5;
    logic        in_fire = 1'b0;
    logic        timed_phase = 1'b0;
    int          cycle_count = 0;
    int          checked = 0;

    branch_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_pc         (in_pc),
        .in_instr      (in_instr),
        .in_pred_taken (in_pred_taken),
        .in_src_a      (in_src_a),
        .in_src_b      (in_src_b),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_pc        (res_pc),
        .res_redirect  (res_redirect),
        .res_target    (res_target),
        .res_dest      (res_dest),
        .res_call      (res_call),
        .res_return    (res_return)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // expected result of one instruction
    function automatic expect_t expect_result(input branch_pkg::addr_t pc,
                                              input branch_pkg::instr_t instr,
                                              input logic pred,
                                              input branch_pkg::word_t a,
                                              input branch_pkg::word_t b);
        expect_t           e;
        logic              is_ctrl;
        logic              taken;
        branch_pkg::addr_t slot;
        branch_pkg::word_t word_off;
        e = '0;
        is_ctrl = 1'b0;
        taken = 1'b0;
        slot = pc + 32'd4;
        word_off = {{16{instr[15]}}, instr[15:0]};
        e.pc = pc;
        case (instr[31:26])
            branch_pkg::OP_BEQ: begin
                is_ctrl = 1'b1;
                taken = (a == b);
                e.dest = slot + (word_off << 2);
            end
            branch_pkg::OP_BNE: begin
                is_ctrl = 1'b1;
                taken = (a != b);
                e.dest = slot + (word_off << 2);
            end
            branch_pkg::OP_BLEZ: begin
                is_ctrl = 1'b1;
                taken = ($signed(a) <= 0);
                e.dest = slot + (word_off << 2);
            end
            branch_pkg::OP_BGTZ: begin
                is_ctrl = 1'b1;
                taken = ($signed(a) > 0);
                e.dest = slot + (word_off << 2);
            end
            branch_pkg::OP_REGIMM: begin
                if (instr[20:16] == branch_pkg::RT_BLTZ || instr[20:16] == branch_pkg::RT_BGEZ) begin
                    is_ctrl = 1'b1;
                    taken = (instr[20:16] == branch_pkg::RT_BLTZ) ? ($signed(a) < 0)
                                                                  : ($signed(a) >= 0);
                    e.dest = slot + (word_off << 2);
                end
            end
            branch_pkg::OP_J, branch_pkg::OP_JAL: begin
                is_ctrl = 1'b1;
                taken = 1'b1;
                e.dest = {slot[31:28], instr[25:0], 2'b00};
                e.call = (instr[31:26] == branch_pkg::OP_JAL);
            end
            branch_pkg::OP_SPECIAL: begin
                if (instr[5:0] == branch_pkg::FN_JR || instr[5:0] == branch_pkg::FN_JALR) begin
                    is_ctrl = 1'b1;
                    taken = 1'b1;
                    e.dest = a;
                    e.call = (instr[5:0] == branch_pkg::FN_JALR);
                    e.ret = (instr[5:0] == branch_pkg::FN_JR) && (instr[25:21] == 5'd31);
                end
            end
            default: begin
                is_ctrl = 1'b0;
            end
        endcase
        e.redirect = is_ctrl && (taken != pred);
        if (e.redirect) begin
            // predicted taken but not taken, resume after the delay slot
            e.target = taken ? e.dest : pc + 32'd8;
        end
        return e;
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_addr(input string name, input branch_pkg::addr_t got,
                              input branch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // one random instruction with its operands
    task automatic build_item();
        logic [31:0]       r;
        logic [3:0]        sel;
        logic [1:0]        pick;
        logic [1:0]        variant;
        logic [4:0]        rs;
        logic [4:0]        rt;
        logic [15:0]       imm;
        logic [25:0]       idx;
        logic [5:0]        op;
        logic [5:0]        fn;
        branch_pkg::word_t a;
        branch_pkg::word_t b;
        r = take_bits(4);
        sel = r[3:0];
        r = take_bits(30);
        in_pc = {r[29:0], 2'b00};
        r = take_bits(16);
        imm = r[15:0];
        r = take_bits(26);
        idx = r[25:0];
        r = take_bits(5);
        rs = r[4:0];
        r = take_bits(5);
        rt = r[4:0];
        a = take_bits(32);
        b = take_bits(32);
        r = take_bits(2);
        pick = r[1:0];
        // zero and equal operands, often enough to hit both outcomes
        if (pick == 2'd0) begin
            a = '0;
        end else if (pick == 2'd1) begin
            b = a;
        end
        if (sel == 4'd8 && pick[1]) begin
            rs = branch_pkg::RA_IDX;
        end
        case (sel)
            4'd0: in_instr = {branch_pkg::OP_BEQ, rs, rt, imm};
            4'd1: in_instr = {branch_pkg::OP_BNE, rs, rt, imm};
            4'd2: in_instr = {branch_pkg::OP_BLEZ, rs, 5'd0, imm};
            4'd3: in_instr = {branch_pkg::OP_BGTZ, rs, 5'd0, imm};
            4'd4: in_instr = {branch_pkg::OP_REGIMM, rs, branch_pkg::RT_BLTZ, imm};
            4'd5: in_instr = {branch_pkg::OP_REGIMM, rs, branch_pkg::RT_BGEZ, imm};
            4'd6: in_instr = {branch_pkg::OP_J, idx};
            4'd7: in_instr = {branch_pkg::OP_JAL, idx};
            4'd8: in_instr = {branch_pkg::OP_SPECIAL, rs, 15'd0, branch_pkg::FN_JR};
            4'd9: in_instr = {branch_pkg::OP_SPECIAL, rs, 5'd0, 5'd31, 5'd0, branch_pkg::FN_JALR};
            default: begin
                r = take_bits(8);
                variant = r[7:6];
                op = r[5:0];
                fn = r[5:0];
                if (variant == 2'd0) begin
                    if (op < 6'd8) begin
                        op = op | 6'b001000;
                    end
                    in_instr = {op, idx};
                end else if (variant == 2'd1) begin
                    if (fn[5:1] == 5'b00100) begin
                        fn = 6'b100001;
                    end
                    in_instr = {branch_pkg::OP_SPECIAL, idx[19:0], fn};
                end else begin
                    // link variants of regimm are not handled
                    if (rt < 5'd2) begin
                        rt = rt + 5'd16;
                    end
                    in_instr = {branch_pkg::OP_REGIMM, rs, rt, imm};
                end
            end
        endcase
        r = take_bits(1);
        in_pred_taken = r[0];
        in_src_a = a;
        in_src_b = b;
    endtask

    task automatic send_items(input int count, input logic gaps);
        int sent;
        sent = 0;
        while (sent < count) begin
            @(negedge clk);
            if (in_valid && in_fire) begin
                sent++;
                in_valid = 1'b0;
            end
            if (gaps) begin
                res_ready = (take_bits(2) != 0);
            end
            if (!in_valid && sent < count) begin
                if (!gaps || take_bits(2) != 0) begin
                    build_item();
                    in_valid = 1'b1;
                end
            end
        end
    endtask

    task automatic drain_results(input logic random_ready);
        while (exp_q.size() != 0) begin
            @(negedge clk);
            if (random_ready) begin
                res_ready = (take_bits(2) != 0);
            end
        end
    endtask

    // input side handshake, expected results in order
    always @(posedge clk) begin : input_monitor
        expect_t e;
        if (reset) begin
            in_fire = 1'b0;
        end else begin
            in_fire = in_valid && in_ready;
            if (in_fire) begin
                e = expect_result(in_pc, in_instr, in_pred_taken, in_src_a, in_src_b);
                e.timed = timed_phase;
                e.accept_cycle = cycle_count;
                exp_q.push_back(e);
            end
        end
    end

    always @(posedge clk) begin : result_compare
        expect_t e;
        if (!reset && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                $display("a result came out with no instruction waiting for it");
                stop_run();
            end else begin
                e = exp_q.pop_front();
                check_addr("res_pc", res_pc, e.pc);
                check_flag("res_redirect", res_redirect, e.redirect);
                check_addr("res_target", res_target, e.target);
                check_addr("res_dest", res_dest, e.dest);
                check_flag("res_call", res_call, e.call);
                check_flag("res_return", res_return, e.ret);
                if (e.timed && (cycle_count - e.accept_cycle) != 3) begin
                    $display("result for pc %h took %0d cycles instead of three", e.pc,
                             cycle_count - e.accept_cycle);
                    stop_run();
                end
                checked++;
            end
        end
    end

    always @(negedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d results checked",
                     cycle_count, checked, TOTAL_ITEMS);
            stop_run();
        end
    end

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_instr = '0;
        in_pred_taken = 1'b0;
        in_src_a = '0;
        in_src_b = '0;
        res_ready = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // random gaps and back-pressure
        send_items(RANDOM_ITEMS, 1'b1);
        drain_results(1'b1);

        // back to back with the consumer always ready
        @(negedge clk);
        res_ready = 1'b1;
        timed_phase = 1'b1;
        send_items(TIMED_ITEMS, 1'b0);
        drain_results(1'b0);
        repeat (4) @(negedge clk);

        if (checked == TOTAL_ITEMS && exp_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("only %0d of %0d results were checked", checked, TOTAL_ITEMS);
            stop_run();
        end
    end

endmodule

// File: verilog.f
hw/branch_pkg.sv
hw/branch_ifs.sv
hw/branch_decode.sv
hw/branch_execute.sv
hw/branch_result.sv
hw/branch_unit.sv
sim/branch_unit_asserts.sv
sim/branch_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the branch unit testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed run returns non-zero.

set -u

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

verilator --binary --assert --timing \
    -f verilog.f \
    --top-module branch_unit_tb \
    -o branch_unit_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/branch_unit_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit "$run_status"
fi

exit 0
